// File: sim.f
common/axi_lite_pkg.sv
common/dtw_pkg.sv
axi_lite/axi_lite_slave.sv
rtl/dtw_regs.sv
rtl/sample_fifo.sv
ref_loader/dtw_ref_loader.sv
rtl/dtw_accel.sv
sim/dtw_accel_chk.sv
sim/tb_dtw_accel.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_dtw_accel \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: sim/tb_dtw_accel.sv
`timescale 1ns/1ps

module tb_dtw_accel;

    localparam int N_TXN     = 140;
    localparam int N_SAMPLES = 11;
    localparam int TIMEOUT_NS = (N_TXN * 12 + N_SAMPLES * 8 + 100) * 8;

    logic        S_AXI_clk = 1'b0;
    logic        w_axi_rst;
    logic        awvalid, wvalid, bready, arvalid, rready, src_tvalid;
    logic [15:0] awaddr, araddr;
    logic [31:0] wdata, src_tdata, rd_word;
    logic        o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_src_tready;
    logic [1:0]  o_bresp, o_rresp;
    logic [31:0] o_rdata;
    int          seed = 32'hb713_7f7e;
    int          polls;

    always #4 S_AXI_clk = ~S_AXI_clk;

    dtw_accel UUT (
        .S_AXI_clk (S_AXI_clk), .w_axi_rst (w_axi_rst),
        .i_awvalid (awvalid),   .i_awaddr  (awaddr),  .o_awready (o_awready),
        .i_wvalid  (wvalid),    .i_wdata   (wdata),   .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),  .i_bready  (bready),  .o_bresp   (o_bresp),
        .i_arvalid (arvalid),   .i_araddr  (araddr),  .o_arready (o_arready),
        .o_rvalid  (o_rvalid),  .i_rready  (rready),  .o_rresp   (o_rresp),
        .o_rdata   (o_rdata),
        .i_src_tvalid (src_tvalid), .i_src_tdata (src_tdata), .o_src_tready (o_src_tready)
    );

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(negedge S_AXI_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        #1;
        while (!o_awready) begin
            @(negedge S_AXI_clk);
            #1;
        end
        @(negedge S_AXI_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // bready stays high, so the response goes at the next edge
        while (!o_bvalid) @(negedge S_AXI_clk);
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        @(negedge S_AXI_clk);
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        while (!o_arready) begin
            @(negedge S_AXI_clk);
            #1;
        end
        @(negedge S_AXI_clk);
        arvalid = 1'b0;
        while (!o_rvalid) @(negedge S_AXI_clk);
        data = o_rdata;
    endtask

    task automatic send_sample();
        @(negedge S_AXI_clk);
        src_tvalid = 1'b1;
        src_tdata  = $random(seed);
        #1;
        while (!o_src_tready) begin
            @(negedge S_AXI_clk);
            #1;
        end
        @(negedge S_AXI_clk);
        src_tvalid = 1'b0;
    endtask

    // Stop at the first failed assertion
    always @(negedge S_AXI_clk) begin
        if (UUT.u_chk.failed) begin
            $display("Finished with errors");
            $fatal(1, "Assertion failure in the checker");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not complete in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        {awvalid, wvalid, arvalid, src_tvalid} = '0;
        {bready, rready} = 2'b11;
        {awaddr, araddr, wdata, src_tdata} = '0;
        w_axi_rst = 1'b1;
        repeat (3) @(posedge S_AXI_clk);
        @(negedge S_AXI_clk);
        w_axi_rst = 1'b0;

        // Identification, then read/write and error paths
        bus_read(16'h0010, rd_word);
        bus_read(16'h000c, rd_word);
        bus_write(16'h0000, 32'h1234_5670);
        bus_read(16'h0000, rd_word);
        bus_write(16'h0008, 32'hffff_f805);
        bus_read(16'h0008, rd_word);
        bus_write(16'h0010, 32'hdead_beef);
        bus_read(16'h0010, rd_word);
        bus_write(16'h0018, 32'h1111_1111);
        bus_read(16'h0018, rd_word);
        bus_write(16'h0020, 32'h2222_2222);
        bus_read(16'h0020, rd_word);
        bus_read(16'h003c, rd_word);

        // Stale beats, then a clear and a fill with the loader idle
        bus_write(16'h0008, 32'd8);
        repeat (2) send_sample();
        bus_write(16'h0000, 32'd1);
        bus_write(16'h0000, 32'd0);
        repeat (4) send_sample();
        @(negedge S_AXI_clk);
        src_tvalid = 1'b1;
        src_tdata  = $random(seed);
        repeat (3) @(negedge S_AXI_clk);
        src_tvalid = 1'b0;

        // Start loading and send the rest of the reference
        bus_write(16'h0000, 32'd6);
        repeat (3) send_sample();
        // One sample short, so load_done must still be low
        bus_read(16'h0004, rd_word);
        send_sample();
        polls = 0;
        rd_word = '0;
        while (!rd_word[1]) begin
            if (polls == 50) begin
                $display("Loader never reported load done");
                $display("Finished with errors");
                $fatal(1, "Load did not finish");
            end
            bus_read(16'h0004, rd_word);
            polls++;
        end

        // Debug read back of every reference word
        for (int k = 0; k < 8; k++) begin
            bus_write(16'h0014, k);
            bus_read(16'h001c, rd_word);
        end
        bus_read(16'h0014, rd_word);

        repeat (3) @(negedge S_AXI_clk);
        if (UUT.u_chk.failed) begin
            $display("Finished with errors");
            $fatal(1, "Assertion failure in the checker");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: sim/dtw_accel_chk.sv
`timescale 1ns/1ps

module dtw_accel_chk import axi_lite_pkg::*, dtw_pkg::*; (
    input logic                  S_AXI_clk,
    input logic                  w_axi_rst,
    input logic                  i_awvalid,
    input logic [AXI_ADDR_W-1:0] i_awaddr,
    input logic                  o_awready,
    input logic                  i_wvalid,
    input logic [AXI_DATA_W-1:0] i_wdata,
    input logic                  o_wready,
    input logic                  o_bvalid,
    input logic [1:0]            o_bresp,
    input logic                  i_arvalid,
    input logic [AXI_ADDR_W-1:0] i_araddr,
    input logic                  o_arready,
    input logic                  o_rvalid,
    input logic                  i_rready,
    input logic [1:0]            o_rresp,
    input logic [AXI_DATA_W-1:0] o_rdata,
    input logic                  i_src_tvalid,
    input logic [STREAM_W-1:0]   i_src_tdata,
    input logic                  o_src_tready
);

    logic [31:0] ctrl_m;
    logic [10:0] ref_len_m;
    logic [9:0]  addr_m;
    logic [15:0] ref_m [1024];
    logic [15:0] beat_cnt;
    logic        load_go;
    logic [3:0]  wr_idx;
    logic [3:0]  rd_idx;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_rresp;
    logic [1:0]  exp_bresp;
    logic        f_rdata = 1'b0;
    logic        f_rresp = 1'b0;
    logic        f_bresp = 1'b0;
    logic        f_wready = 1'b0;
    logic        f_status = 1'b0;
    logic        f_fill = 1'b0;
    logic        f_full = 1'b0;
    logic        failed;

    assign failed = f_rdata | f_rresp | f_bresp | f_wready | f_status | f_fill | f_full;

    // Bus and stream snooping model
    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            ctrl_m    <= '0;
            ref_len_m <= '0;
            addr_m    <= '0;
            beat_cnt  <= '0;
            load_go   <= 1'b0;
            wr_idx    <= '0;
            rd_idx    <= '0;
        end else begin
            if (i_src_tvalid && o_src_tready) begin
                ref_m[beat_cnt[9:0]] <= i_src_tdata[15:0];
                beat_cnt <= beat_cnt + 16'd1;
            end
            if (i_awvalid && o_awready) begin
                wr_idx <= i_awaddr[5:2];
                case (i_awaddr[5:2])
                    4'd0: begin
                        ctrl_m  <= i_wdata;
                        load_go <= i_wdata[1] && i_wdata[2] && !i_wdata[0];
                        if (i_wdata[0]) beat_cnt <= '0;
                    end
                    4'd2: ref_len_m <= i_wdata[10:0];
                    4'd5: addr_m <= i_wdata[9:0];
                    default: ;
                endcase
            end
            if (i_arvalid && o_arready) rd_idx <= i_araddr[5:2];
        end
    end

    always_comb begin
        case (rd_idx)
            4'd0:    exp_rdata = ctrl_m;
            4'd2:    exp_rdata = {21'd0, ref_len_m};
            4'd3:    exp_rdata = 32'h1000_0000;
            4'd4:    exp_rdata = 32'h0ca7_cafe;
            4'd5:    exp_rdata = {22'd0, addr_m};
            4'd7:    exp_rdata = {16'd0, ref_m[addr_m]};
            default: exp_rdata = 32'd0;
        endcase
    end

    // Unmapped indexes answer with SLVERR
    assign exp_rresp = (rd_idx == 4'd6 || rd_idx > 4'd7) ? 2'h2 : 2'h0;
    assign exp_bresp = (wr_idx == 4'd6 || wr_idx > 4'd7) ? 2'h2 : 2'h0;

    a_rdata: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        (o_rvalid && i_rready && rd_idx != 4'(REG_STATUS)) |-> (o_rdata == exp_rdata))
        else begin
            $error("[ERROR] o_rdata idx %h: got %h expected %h", rd_idx, o_rdata, exp_rdata);
            f_rdata = 1'b1;
        end

    a_rresp: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        o_rvalid |-> (o_rresp == exp_rresp))
        else begin
            $error("[ERROR] o_rresp idx %h: got %h expected %h", rd_idx, o_rresp, exp_rresp);
            f_rresp = 1'b1;
        end

    a_bresp: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        o_bvalid |-> (o_bresp == exp_bresp))
        else begin
            $error("[ERROR] o_bresp idx %h: got %h expected %h", wr_idx, o_bresp, exp_bresp);
            f_bresp = 1'b1;
        end

    // Address and data are taken together, and only when both are offered
    a_wready: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        (o_awready || o_wready) |-> (o_awready && o_wready && i_awvalid && i_wvalid))
        else begin
            $error("[ERROR] o_wready: got %h expected %h", o_wready,
                   o_awready && i_awvalid && i_wvalid);
            f_wready = 1'b1;
        end

    // load_done only after all reference samples arrived
    a_status: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        (o_rvalid && rd_idx == 4'(REG_STATUS)) |->
            (o_rdata[31:4] == '0 && (!o_rdata[1] || (load_go && beat_cnt >= 16'(ref_len_m)))))
        else begin
            $error("[ERROR] o_rdata status: got %h beats %h", o_rdata, beat_cnt);
            f_status = 1'b1;
        end

    a_fill: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        !load_go |-> (beat_cnt <= 16'd4))
        else begin
            $error("[ERROR] beat_cnt: got %h limit %h", beat_cnt, 16'd4);
            f_fill = 1'b1;
        end

    a_full: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        (!load_go && beat_cnt == 16'd4) |-> !o_src_tready)
        else begin
            $error("[ERROR] o_src_tready: got %h expected %h", o_src_tready, 1'b0);
            f_full = 1'b1;
        end

endmodule

bind dtw_accel dtw_accel_chk u_chk (.*);

// File: rtl/dtw_accel.sv
`timescale 1ns/1ps

module dtw_accel import axi_lite_pkg::*, dtw_pkg::*; (
    input  logic                  S_AXI_clk,
    input  logic                  w_axi_rst,

    // AXI-lite
    input  logic                  i_awvalid,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  logic                  i_wvalid,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    output logic                  o_wready,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    output logic [1:0]            o_bresp,
    input  logic                  i_arvalid,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output logic [1:0]            o_rresp,
    output logic [AXI_DATA_W-1:0] o_rdata,

    // Sample stream
    input  logic                  i_src_tvalid,
    input  logic [STREAM_W-1:0]   i_src_tdata,
    output logic                  o_src_tready
);

    reg_req_t              w_req;
    reg_rsp_t              w_rsp;
    ctrl_u                 w_ctrl;
    logic [REF_ADDR_W:0]   w_ref_len;
    logic [REF_ADDR_W-1:0] w_dbg_addr;
    logic [SAMPLE_W-1:0]   w_dbg_dout;
    logic                  w_busy;
    logic                  w_load_done;
    logic                  w_fifo_empty;
    logic                  w_fifo_full;
    logic                  w_pop;
    logic [STREAM_W-1:0]   w_head;

    axi_lite_slave u_slave (
        .S_AXI_clk (S_AXI_clk),  .w_axi_rst (w_axi_rst),
        .i_awvalid (i_awvalid),  .i_awaddr  (i_awaddr),  .o_awready (o_awready),
        .i_wvalid  (i_wvalid),   .i_wdata   (i_wdata),   .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),   .i_bready  (i_bready),  .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),  .i_araddr  (i_araddr),  .o_arready (o_arready),
        .o_rvalid  (o_rvalid),   .i_rready  (i_rready),  .o_rresp   (o_rresp),
        .o_rdata   (o_rdata),    .o_req     (w_req),     .i_rsp     (w_rsp)
    );

    dtw_regs u_regs (
        .S_AXI_clk    (S_AXI_clk),    .w_axi_rst   (w_axi_rst),
        .i_req        (w_req),        .o_rsp       (w_rsp),
        .o_ctrl       (w_ctrl),       .o_ref_len   (w_ref_len),
        .o_dbg_addr   (w_dbg_addr),   .i_busy      (w_busy),
        .i_load_done  (w_load_done),  .i_fifo_empty (w_fifo_empty),
        .i_fifo_full  (w_fifo_full),  .i_dbg_dout  (w_dbg_dout)
    );

    // Cleared together with the loader
    sample_fifo u_fifo (
        .S_AXI_clk (S_AXI_clk),    .w_axi_rst (w_axi_rst),
        .i_clear   (w_ctrl.bits.core_rst),
        .i_tvalid  (i_src_tvalid), .i_tdata   (i_src_tdata), .o_tready (o_src_tready),
        .i_pop     (w_pop),        .o_head    (w_head),
        .o_empty   (w_fifo_empty), .o_full    (w_fifo_full)
    );

    // Only the low sample bits reach the reference memory
    dtw_ref_loader u_loader (
        .S_AXI_clk    (S_AXI_clk),    .w_axi_rst   (w_axi_rst),
        .i_ctrl       (w_ctrl),       .i_ref_len   (w_ref_len),
        .i_fifo_empty (w_fifo_empty), .i_fifo_head (w_head[SAMPLE_W-1:0]),
        .o_pop        (w_pop),        .o_busy      (w_busy),
        .o_load_done  (w_load_done),  .i_dbg_addr  (w_dbg_addr),
        .o_dbg_dout   (w_dbg_dout)
    );

endmodule

// File: ref_loader/dtw_ref_loader.sv
`timescale 1ns/1ps

module dtw_ref_loader import dtw_pkg::*; (
    input  logic                  S_AXI_clk,
    input  logic                  w_axi_rst,
    input  ctrl_u                 i_ctrl,
    input  logic [REF_ADDR_W:0]   i_ref_len,

    // Source FIFO
    input  logic                  i_fifo_empty,
    input  logic [SAMPLE_W-1:0]   i_fifo_head,
    output logic                  o_pop,

    output logic                  o_busy,
    output logic                  o_load_done,

    // Debug read port
    input  logic [REF_ADDR_W-1:0] i_dbg_addr,
    output logic [SAMPLE_W-1:0]   o_dbg_dout
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DONE
    } state_t;

    state_t              r_state;
    logic [REF_ADDR_W:0] r_wr_addr;
    logic [REF_ADDR_W:0] w_last;
    logic [SAMPLE_W-1:0] r_mem [REF_DEPTH];
    logic [SAMPLE_W-1:0] r_dbg_dout;

    assign w_last = i_ref_len - 1'b1;

    // One word per cycle while samples are waiting
    assign o_pop       = (r_state == ST_LOAD) && !i_fifo_empty;
    assign o_busy      = (r_state == ST_LOAD);
    assign o_load_done = (r_state == ST_DONE);

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_ctrl.bits.core_rst) begin
            r_state   <= ST_IDLE;
            r_wr_addr <= '0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    r_wr_addr <= '0;
                    if (i_ctrl.bits.run && i_ctrl.bits.load_mode) begin
                        // Nothing to load for an empty reference
                        r_state <= (i_ref_len == '0) ? ST_DONE : ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (o_pop) begin
                        r_wr_addr <= r_wr_addr + 1'b1;
                        if (r_wr_addr == w_last) r_state <= ST_DONE;
                    end
                end
                ST_DONE: ;  // held until core_rst
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // Reference memory with registered debug read
    always_ff @(posedge S_AXI_clk) begin
        if (o_pop) r_mem[r_wr_addr[REF_ADDR_W-1:0]] <= i_fifo_head;
        r_dbg_dout <= r_mem[i_dbg_addr];
    end

    assign o_dbg_dout = r_dbg_dout;

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import dtw_pkg::*; (
    input  logic                S_AXI_clk,
    input  logic                w_axi_rst,
    input  logic                i_clear,
    input  logic                i_tvalid,
    input  logic [STREAM_W-1:0] i_tdata,
    output logic                o_tready,
    input  logic                i_pop,
    output logic [STREAM_W-1:0] o_head,
    output logic                o_empty,
    output logic                o_full
);

    logic [STREAM_W-1:0]   r_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] r_wr_ptr;
    logic [FIFO_PTR_W-1:0] r_rd_ptr;
    logic [FIFO_PTR_W:0]   r_count;
    logic                  w_push;
    logic                  w_pop;

    assign o_empty  = (r_count == '0);
    assign o_full   = (r_count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign o_tready = !o_full;
    assign o_head   = r_mem[r_rd_ptr];

    // Beat taken on valid and ready
    assign w_push = i_tvalid && o_tready;
    assign w_pop  = i_pop && !o_empty;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_clear) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) r_wr_ptr <= r_wr_ptr + 1'b1;
            if (w_pop) r_rd_ptr <= r_rd_ptr + 1'b1;
            r_count <= r_count + {{FIFO_PTR_W{1'b0}}, w_push} - {{FIFO_PTR_W{1'b0}}, w_pop};
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_push) r_mem[r_wr_ptr] <= i_tdata;
    end

endmodule

// File: rtl/dtw_regs.sv
`timescale 1ns/1ps

module dtw_regs import axi_lite_pkg::*, dtw_pkg::*; (
    input  logic                  S_AXI_clk,
    input  logic                  w_axi_rst,
    input  reg_req_t              i_req,
    output reg_rsp_t              o_rsp,

    // Loader control
    output ctrl_u                 o_ctrl,
    output logic [REF_ADDR_W:0]   o_ref_len,
    output logic [REF_ADDR_W-1:0] o_dbg_addr,

    // Status inputs
    input  logic                  i_busy,
    input  logic                  i_load_done,
    input  logic                  i_fifo_empty,
    input  logic                  i_fifo_full,
    input  logic [SAMPLE_W-1:0]   i_dbg_dout
);

    ctrl_u                 r_ctrl;
    logic [REF_ADDR_W:0]   r_ref_len;
    logic [REF_ADDR_W-1:0] r_dbg_addr;
    logic                  r_done;
    logic                  r_err;
    logic [AXI_DATA_W-1:0] r_rdata;
    status_t               w_status;
    logic                  w_hit;
    logic [AXI_DATA_W-1:0] w_rdata;

    always_comb begin
        w_status            = '0;
        w_status.busy       = i_busy;
        w_status.load_done  = i_load_done;
        w_status.fifo_empty = i_fifo_empty;
        w_status.fifo_full  = i_fifo_full;
    end

    // Index decode shared by reads and writes
    always_comb begin
        w_hit   = 1'b1;
        w_rdata = '0;
        case (i_req.idx)
            REG_CONTROL:  w_rdata = r_ctrl.raw;
            REG_STATUS:   w_rdata = w_status;
            REG_REF_LEN:  w_rdata = {{(AXI_DATA_W-REF_ADDR_W-1){1'b0}}, r_ref_len};
            REG_VERSION:  w_rdata = VERSION_WORD;
            REG_KEY:      w_rdata = KEY_WORD;
            REG_REF_ADDR: w_rdata = {{(AXI_DATA_W-REF_ADDR_W){1'b0}}, r_dbg_addr};
            REG_REF_DOUT: w_rdata = {{(AXI_DATA_W-SAMPLE_W){1'b0}}, i_dbg_dout};
            default:      w_hit = 1'b0;
        endcase
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            r_ctrl.raw <= '0;
            r_ref_len  <= '0;
            r_dbg_addr <= '0;
            r_done     <= 1'b0;
            r_err      <= 1'b0;
        end else begin
            r_done <= i_req.wr || i_req.rd;
            r_err  <= (i_req.wr || i_req.rd) && !w_hit;
            if (i_req.wr) begin
                // Read-only registers quietly ignore writes
                case (i_req.idx)
                    REG_CONTROL:  r_ctrl.raw <= i_req.wdata;
                    REG_REF_LEN:  r_ref_len  <= i_req.wdata[REF_ADDR_W:0];
                    REG_REF_ADDR: r_dbg_addr <= i_req.wdata[REF_ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (i_req.rd) begin
            r_rdata <= w_rdata;
        end
    end

    always_comb begin
        o_rsp.done  = r_done;
        o_rsp.err   = r_err;
        o_rsp.rdata = r_rdata;
    end

    assign o_ctrl     = r_ctrl;
    assign o_ref_len  = r_ref_len;
    assign o_dbg_addr = r_dbg_addr;

endmodule

// File: axi_lite/axi_lite_slave.sv
`timescale 1ns/1ps

module axi_lite_slave import axi_lite_pkg::*; (
    input  logic                  S_AXI_clk,
    input  logic                  w_axi_rst,

    // Write address and data
    input  logic                  i_awvalid,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  logic                  i_wvalid,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    output logic                  o_wready,

    // Write response
    output logic                  o_bvalid,
    input  logic                  i_bready,
    output logic [1:0]            o_bresp,

    // Read address and data
    input  logic                  i_arvalid,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output logic [1:0]            o_rresp,
    output logic [AXI_DATA_W-1:0] o_rdata,

    // Register side
    output reg_req_t              o_req,
    input  reg_rsp_t              i_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t                r_state;
    logic                  r_wr_stb;
    logic                  r_rd_stb;
    logic                  r_is_wr;
    logic [REG_IDX_W-1:0]  r_idx;
    logic [AXI_DATA_W-1:0] r_wdata;
    logic [AXI_DATA_W-1:0] r_rdata;
    logic [1:0]            r_resp;
    logic                  r_bvalid;
    logic                  r_rvalid;
    logic                  w_wr_go;
    logic                  w_rd_go;

    // Writes win when both directions arrive together
    assign w_wr_go = (r_state == ST_IDLE) && i_awvalid && i_wvalid;
    assign w_rd_go = (r_state == ST_IDLE) && i_arvalid && !(i_awvalid && i_wvalid);

    assign o_awready = w_wr_go;
    assign o_wready  = w_wr_go;
    assign o_arready = w_rd_go;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            r_state  <= ST_IDLE;
            r_wr_stb <= 1'b0;
            r_rd_stb <= 1'b0;
            r_bvalid <= 1'b0;
            r_rvalid <= 1'b0;
        end else begin
            r_wr_stb <= 1'b0;
            r_rd_stb <= 1'b0;
            case (r_state)
                ST_IDLE: begin
                    if (w_wr_go) begin
                        r_wr_stb <= 1'b1;
                        r_state  <= ST_WAIT;
                    end else if (w_rd_go) begin
                        r_rd_stb <= 1'b1;
                        r_state  <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_rsp.done) begin
                        r_bvalid <= r_is_wr;
                        r_rvalid <= !r_is_wr;
                        r_state  <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // Hold until the master takes it
                    if ((r_bvalid && i_bready) || (r_rvalid && i_rready)) begin
                        r_bvalid <= 1'b0;
                        r_rvalid <= 1'b0;
                        r_state  <= ST_IDLE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // Captured address, data and answer
    always_ff @(posedge S_AXI_clk) begin
        if (r_state == ST_IDLE) begin
            r_is_wr <= w_wr_go;
            if (w_wr_go) begin
                r_idx   <= i_awaddr[REG_IDX_W+1:2];
                r_wdata <= i_wdata;
            end else if (w_rd_go) begin
                r_idx <= i_araddr[REG_IDX_W+1:2];
            end
        end
        if ((r_state == ST_WAIT) && i_rsp.done) begin
            r_rdata <= i_rsp.rdata;
            r_resp  <= i_rsp.err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_comb begin
        o_req.wr    = r_wr_stb;
        o_req.rd    = r_rd_stb;
        o_req.idx   = r_idx;
        o_req.wdata = r_wdata;
    end

    assign o_bvalid = r_bvalid;
    assign o_bresp  = r_resp;
    assign o_rvalid = r_rvalid;
    assign o_rresp  = r_resp;
    assign o_rdata  = r_rdata;

endmodule

// File: common/dtw_pkg.sv
package dtw_pkg;

    // Register word indexes
    localparam int REG_CONTROL  = 0;
    localparam int REG_STATUS   = 1;
    localparam int REG_REF_LEN  = 2;
    localparam int REG_VERSION  = 3;
    localparam int REG_KEY      = 4;
    localparam int REG_REF_ADDR = 5;
    localparam int REG_REF_DOUT = 7;

    // Version fields, packed as major, minor, revision
    localparam logic [3:0] VER_MAJOR    = 4'd1;
    localparam logic [7:0] VER_MINOR    = 8'd0;
    localparam logic [3:0] VER_REVISION = 4'd0;
    localparam logic [31:0] VERSION_WORD = {VER_MAJOR, VER_MINOR, VER_REVISION, 16'h0000};

    // Identification constant
    localparam logic [31:0] KEY_WORD = 32'h0ca7cafe;

    // Data paths
    localparam int SAMPLE_W   = 16;
    localparam int STREAM_W   = 32;
    localparam int REF_ADDR_W = 10;
    localparam int REF_DEPTH  = 1024;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Control word, seen raw or as command bits
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [28:0] pad;
            logic        load_mode;
            logic        run;
            logic        core_rst;
        } bits;
    } ctrl_u;

    // Status word
    typedef struct packed {
        logic [27:0] pad;
        logic        fifo_full;
        logic        fifo_empty;
        logic        load_done;
        logic        busy;
    } status_t;

endpackage

// File: common/axi_lite_pkg.sv
package axi_lite_pkg;

    // Bus widths
    localparam int AXI_ADDR_W = 16;
    localparam int AXI_DATA_W = 32;

    // Word index taken from the address above the byte lane bits
    localparam int REG_IDX_W = 4;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Single register access from the slave
    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic [REG_IDX_W-1:0]  idx;
        logic [AXI_DATA_W-1:0] wdata;
    } reg_req_t;

    // Answer from the register file, one cycle after the request
    typedef struct packed {
        logic                  done;
        logic                  err;
        logic [AXI_DATA_W-1:0] rdata;
    } reg_rsp_t;

endpackage
